// File: compile.f
+incdir+include
design/cpuPkg.sv
design/registerFile.sv
design/aluUnit.sv
design/memAlign.sv
design/multiCycleControl.sv
design/multiCycleCpu.sv
verif/cpuTb.sv

// File: design/aluUnit.sv
`include "cpu_cfg.svh"

module aluUnit
	import cpuPkg::*;
(
	input aluClassT aluClass,
	input opcodeT opcode,
	input functT funct,
	input wordT operandA,
	input wordT operandB,
	output wordT result,
	output logic zero
);

	aluCtrlT aluCtrl;

	// Class from the FSM to actual operation
	always_comb
	begin
		aluCtrl = aluAdd;
		case (aluClass)
			classAddrAdd: aluCtrl = aluAdd; // PC step, addresses, addi
			classBranchCmp: aluCtrl = aluSub; // Zero flag gives equality
			classRType:
			begin
				case (funct)
					`cpuFnAdd: aluCtrl = aluAdd;
					`cpuFnSub: aluCtrl = aluSub;
					`cpuFnAnd: aluCtrl = aluAnd;
					`cpuFnOr: aluCtrl = aluOr;
					`cpuFnSlt: aluCtrl = aluSlt;
					default: aluCtrl = aluAdd; // Unknown funct behaves as add
				endcase
			end
			classImmLogic:
			begin
				// Only the two logic immediates come here
				case (opcode)
					`cpuOpAndi: aluCtrl = aluAnd;
					`cpuOpOri: aluCtrl = aluOr;
					default: aluCtrl = aluAdd;
				endcase
			end
			default: aluCtrl = aluAdd;
		endcase
	end

	// Arithmetic, no overflow flag
	always_comb
	begin
		case (aluCtrl)
			aluAdd: result = operandA + operandB;
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			aluSlt:
			begin
				// Signed compare, result is 0 or 1
				result = ($signed(operandA) < $signed(operandB)) ? wordT'(1) : '0;
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // Used by top for beq/bne

endmodule

// File: design/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

	typedef logic [`cpuWordWidth-1:0] wordT; // Data word or byte address
	typedef logic [`cpuRegAddrWidth-1:0] regAddrT;
	typedef logic [5:0] opcodeT; // ir[31:26]
	typedef logic [5:0] functT; // ir[5:0]
	typedef logic [3:0] byteEnT; // One bit per byte lane
	typedef logic [1:0] byteOffsetT; // Low address bits

	// What the FSM asks of the ALU
	typedef enum logic [1:0]
	{
		classAddrAdd, // Plain add
		classBranchCmp, // Subtract for beq/bne
		classRType, // Decode from funct
		classImmLogic // andi or ori
	} aluClassT;

	typedef enum logic [2:0]
	{
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluCtrlT;

	typedef enum logic
	{
		srcAPc,
		srcARegA
	} aluSrcAT;

	typedef enum logic [2:0]
	{
		srcBRegB,
		srcBPcStep,
		srcBSignImm,
		srcBBranchOff, // Sign-extended offset times 4
		srcBZeroImm
	} aluSrcBT;

	typedef enum logic [1:0]
	{
		pcFromAluResult, // Sequential PC + 4
		pcFromAluOut, // Branch target from decode
		pcFromJump,
		pcFromRegA // jr
	} pcSrcT;

	typedef enum logic [3:0]
	{
		stFetch,
		stDecode,
		stMemAddr,
		stMemRead,
		stLoadWb,
		stMemWrite,
		stRExec,
		stAluWb,
		stImmExec,
		stBranch,
		stJump,
		stJal,
		stJr
	} ctrlStateT;

	// Access width for lane steering and load extension
	typedef enum logic [1:0]
	{
		accessWord,
		accessByteSigned,
		accessByteUnsigned
	} accessT;

endpackage

// File: design/memAlign.sv
`include "cpu_cfg.svh"

module memAlign
	import cpuPkg::*;
(
	input accessT access,
	input byteOffsetT storeOffset,
	input wordT storeData,
	output wordT laneData,
	output byteEnT byteEn,
	input byteOffsetT loadOffset,
	input wordT readWord,
	output wordT loadData
);

	logic [7:0] loadByte;

	// Store side
	always_comb
	begin
		if (access == accessWord)
		begin
			laneData = storeData; // All four lanes
			byteEn = '1;
		end
		else
		begin
			// Low byte on every lane, enable picks the one that lands
			laneData = {(`cpuWordWidth / 8){storeData[7:0]}};
			byteEn = byteEnT'(1) << storeOffset;
		end
	end

	// Little-endian byte pick by offset of the earlier read
	assign loadByte = readWord[{loadOffset, 3'b000} +: 8];

	// Load side
	always_comb
	begin
		case (access)
			accessByteSigned:
			begin
				loadData = {{(`cpuWordWidth - 8){loadByte[7]}}, loadByte}; // lb
			end
			accessByteUnsigned:
			begin
				loadData = {{(`cpuWordWidth - 8){1'b0}}, loadByte}; // lbu
			end
			default: loadData = readWord; // lw untouched
		endcase
	end

endmodule

// File: design/multiCycleControl.sv
`include "cpu_cfg.svh"

module multiCycleControl
	import cpuPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input opcodeT opcode,
	input functT funct,
	output logic irWrite,
	output logic iOrD,
	output logic pcWrite,
	output logic pcWriteBeq,
	output logic pcWriteBne,
	output pcSrcT pcSrc,
	output aluClassT aluClass,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output logic regWrite,
	output logic regDst,
	output logic memToReg,
	output logic linkWrite,
	output logic memReadEn,
	output logic memWriteEn,
	output accessT access
);

	ctrlStateT state;
	ctrlStateT nextState;
	accessT opAccess; // Width implied by the opcode
	logic isStore;

	assign isStore = (opcode == `cpuOpSw) || (opcode == `cpuOpSb);

	always_comb
	begin
		case (opcode)
			`cpuOpLb, `cpuOpSb: opAccess = accessByteSigned; // sb only needs "byte"
			`cpuOpLbu: opAccess = accessByteUnsigned;
			`cpuOpLw, `cpuOpSw: opAccess = accessWord;
			default: opAccess = accessWord;
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= stFetch;
		else
			state <= nextState;
	end

	// Sequencing, one state per edge
	always_comb
	begin
		nextState = stFetch;
		case (state)
			stFetch: nextState = stDecode;
			stDecode:
			begin
				case (opcode)
					`cpuOpRType: nextState = (funct == `cpuFnJr) ? stJr : stRExec;
					`cpuOpLw, `cpuOpLb, `cpuOpLbu: nextState = stMemAddr;
					`cpuOpSw, `cpuOpSb: nextState = stMemAddr;
					`cpuOpAddi, `cpuOpAndi, `cpuOpOri: nextState = stImmExec;
					`cpuOpBeq, `cpuOpBne: nextState = stBranch;
					`cpuOpJ: nextState = stJump;
					`cpuOpJal: nextState = stJal;
					default: nextState = stFetch; // Unknown opcode is a nop
				endcase
			end
			stMemAddr: nextState = isStore ? stMemWrite : stMemRead;
			stMemRead: nextState = stLoadWb;
			stRExec: nextState = stAluWb;
			stImmExec: nextState = stAluWb;
			default: nextState = stFetch; // Writebacks, branch and jumps end here
		endcase
	end

	// Selects and enables per state
	always_comb
	begin
		irWrite = 1'b0;
		iOrD = 1'b0; // PC drives the address
		pcWrite = 1'b0;
		pcWriteBeq = 1'b0;
		pcWriteBne = 1'b0;
		pcSrc = pcFromAluResult;
		aluClass = classAddrAdd;
		aluSrcA = srcARegA; // A + imm by default, keeps the address stable
		aluSrcB = srcBSignImm;
		regWrite = 1'b0;
		regDst = 1'b0;
		memToReg = 1'b0;
		linkWrite = 1'b0;
		memReadEn = 1'b0;
		memWriteEn = 1'b0;
		access = accessWord;
		case (state)
			stFetch:
			begin
				memReadEn = 1'b1;
				irWrite = 1'b1;
				aluSrcA = srcAPc;
				aluSrcB = srcBPcStep;
				pcWrite = 1'b1; // PC + 4 straight from the ALU
			end
			stDecode:
			begin
				aluSrcA = srcAPc; // Branch target lands in ALU output reg
				aluSrcB = srcBBranchOff;
			end
			stMemAddr:
			begin
				aluSrcA = srcARegA;
				aluSrcB = srcBSignImm;
			end
			stMemRead:
			begin
				iOrD = 1'b1;
				memReadEn = 1'b1;
			end
			stLoadWb:
			begin
				regWrite = 1'b1; // Into rt
				memToReg = 1'b1;
				access = opAccess;
			end
			stMemWrite:
			begin
				iOrD = 1'b1;
				memWriteEn = 1'b1;
				access = opAccess; // Lane steering
			end
			stRExec:
			begin
				aluClass = classRType;
				aluSrcB = srcBRegB;
			end
			stImmExec:
			begin
				if (opcode == `cpuOpAddi)
					aluSrcB = srcBSignImm;
				else
				begin
					aluClass = classImmLogic;
					aluSrcB = srcBZeroImm; // andi/ori zero-extend
				end
			end
			stAluWb:
			begin
				regWrite = 1'b1;
				regDst = (opcode == `cpuOpRType); // rd for R-type, else rt
			end
			stBranch:
			begin
				aluClass = classBranchCmp;
				aluSrcB = srcBRegB;
				pcSrc = pcFromAluOut;
				pcWriteBeq = (opcode == `cpuOpBeq);
				pcWriteBne = (opcode == `cpuOpBne);
			end
			stJump:
			begin
				pcWrite = 1'b1;
				pcSrc = pcFromJump;
			end
			stJal:
			begin
				pcWrite = 1'b1;
				pcSrc = pcFromJump;
				regWrite = 1'b1;
				linkWrite = 1'b1; // Old PC, already + 4, into ra
			end
			stJr:
			begin
				pcWrite = 1'b1;
				pcSrc = pcFromRegA;
			end
			default:
			begin
				irWrite = 1'b0;
			end
		endcase
	end

endmodule

// File: design/multiCycleCpu.sv
`include "cpu_cfg.svh"

module multiCycleCpu
	import cpuPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input wordT initialPc,
	output wordT memAddr,
	output wordT memWriteData,
	input wordT memReadData,
	output logic memWriteEn,
	output logic memReadEn,
	output byteEnT memByteEn
);

	// Architectural and holding registers
	wordT pc;
	wordT ir;
	wordT mdr;
	wordT regA;
	wordT regB;
	wordT aluOut;
	byteOffsetT lastOffset; // Low bits of the latest data access

	opcodeT opcode;
	functT funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	regAddrT writeAddr;
	wordT signImm;
	wordT zeroImm;
	wordT branchOff;
	wordT jumpTarget;
	wordT readData1;
	wordT readData2;
	wordT aluA;
	wordT aluB;
	wordT aluResult;
	wordT loadData;
	wordT writeData;
	wordT pcNext;
	logic aluZero;
	logic pcLoad;

	// Controller outputs
	logic irWrite;
	logic iOrD;
	logic pcWrite;
	logic pcWriteBeq;
	logic pcWriteBne;
	logic regWrite;
	logic regDst;
	logic memToReg;
	logic linkWrite;
	pcSrcT pcSrc;
	aluClassT aluClass;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	accessT access;

	// Instruction fields
	assign opcode = ir[31:26];
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign funct = ir[5:0];
	assign signImm = {{(`cpuWordWidth - 16){ir[15]}}, ir[15:0]};
	assign zeroImm = {{(`cpuWordWidth - 16){1'b0}}, ir[15:0]};
	assign branchOff = {{(`cpuWordWidth - 18){ir[15]}}, ir[15:0], 2'b00}; // Word offset
	assign jumpTarget = {pc[31:28], ir[25:0], 2'b00}; // Region of PC + 4

	always_comb
	begin
		case (aluSrcA)
			srcAPc: aluA = pc;
			default: aluA = regA;
		endcase
	end

	always_comb
	begin
		case (aluSrcB)
			srcBRegB: aluB = regB;
			srcBPcStep: aluB = wordT'(`cpuPcStep);
			srcBSignImm: aluB = signImm;
			srcBBranchOff: aluB = branchOff;
			srcBZeroImm: aluB = zeroImm;
			default: aluB = '0;
		endcase
	end

	always_comb
	begin
		case (pcSrc)
			pcFromAluResult: pcNext = aluResult;
			pcFromAluOut: pcNext = aluOut; // Target saved in decode
			pcFromJump: pcNext = jumpTarget;
			default: pcNext = regA; // jr
		endcase
	end

	// Branch taken when the compare agrees with the branch kind
	assign pcLoad = pcWrite || (pcWriteBeq && aluZero) || (pcWriteBne && !aluZero);

	// Link overrides the normal destination
	assign writeAddr = linkWrite ? regAddrT'(`cpuRaReg) : (regDst ? rd : rt);
	assign writeData = linkWrite ? pc : (memToReg ? loadData : aluOut);

	assign memAddr = iOrD ? aluOut : pc; // Data access or fetch

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pc <= initialPc;
			ir <= '0;
			mdr <= '0;
			regA <= '0;
			regB <= '0;
			aluOut <= '0;
			lastOffset <= '0;
		end
		else
		begin
			regA <= readData1; // Operands refreshed every cycle
			regB <= readData2;
			aluOut <= aluResult;
			if (memReadEn)
				mdr <= memReadData;
			if (irWrite)
				ir <= memReadData;
			if (pcLoad)
				pc <= pcNext;
			if (iOrD)
				lastOffset <= memAddr[1:0]; // For the load writeback after it
		end
	end

	registerFile regFile_i (
		.iCLK(iCLK),
		.iRST(iRST),
		.readAddr1(rs),
		.readAddr2(rt),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(regWrite),
		.readData1(readData1),
		.readData2(readData2)
	);

	aluUnit alu_i (
		.aluClass(aluClass),
		.opcode(opcode),
		.funct(funct),
		.operandA(aluA),
		.operandB(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

	memAlign align_i (
		.access(access),
		.storeOffset(memAddr[1:0]),
		.storeData(regB),
		.laneData(memWriteData),
		.byteEn(memByteEn),
		.loadOffset(lastOffset),
		.readWord(mdr),
		.loadData(loadData)
	);

	multiCycleControl control_i (
		.iCLK(iCLK),
		.iRST(iRST),
		.opcode(opcode),
		.funct(funct),
		.irWrite(irWrite),
		.iOrD(iOrD),
		.pcWrite(pcWrite),
		.pcWriteBeq(pcWriteBeq),
		.pcWriteBne(pcWriteBne),
		.pcSrc(pcSrc),
		.aluClass(aluClass),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.regWrite(regWrite),
		.regDst(regDst),
		.memToReg(memToReg),
		.linkWrite(linkWrite),
		.memReadEn(memReadEn),
		.memWriteEn(memWriteEn),
		.access(access)
	);

endmodule

// File: design/registerFile.sv
`include "cpu_cfg.svh"

module registerFile
	import cpuPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input regAddrT readAddr1,
	input regAddrT readAddr2,
	input regAddrT writeAddr,
	input wordT writeData,
	input logic writeEn,
	output wordT readData1,
	output wordT readData2
);

	wordT regs [`cpuRegCount];

	// Reads are combinational
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1]; // r0 reads zero
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			// Whole bank cleared
			for (int i = 0; i < `cpuRegCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn && (writeAddr != '0)) // r0 write ignored
		begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

// File: include/cpu_cfg.svh
`ifndef cpuCfgSvh
`define cpuCfgSvh

// Datapath widths
`define cpuWordWidth 32
`define cpuRegAddrWidth 5
`define cpuRegCount 32 // r0 included, always reads zero
`define cpuRaReg 31 // jal link target
`define cpuPcStep 4 // Bytes per instruction

// Primary opcodes of the kept set
`define cpuOpRType 6'h00
`define cpuOpJ 6'h02
`define cpuOpJal 6'h03
`define cpuOpBeq 6'h04
`define cpuOpBne 6'h05
`define cpuOpAddi 6'h08
`define cpuOpAndi 6'h0c
`define cpuOpOri 6'h0d
`define cpuOpLb 6'h20
`define cpuOpLw 6'h23
`define cpuOpLbu 6'h24
`define cpuOpSb 6'h28
`define cpuOpSw 6'h2b

// Funct codes when opcode is R-type
`define cpuFnJr 6'h08
`define cpuFnAdd 6'h20
`define cpuFnSub 6'h22
`define cpuFnAnd 6'h24
`define cpuFnOr 6'h25
`define cpuFnSlt 6'h2a

`endif

// File: verif/cpuTb.sv
`include "cpu_cfg.svh"

module cpuTb
	import cpuPkg::*;
();

	localparam wordT progBase = 32'h0000_0100; // Reset PC
	localparam wordT subBase = 32'h0000_0400; // jal target
	localparam wordT dataBase = 32'h0000_0600; // Random operands
	localparam wordT resBase = 32'h0000_0700; // Stored results
	localparam int memWords = 512; // 2 KB

	logic iCLK;
	logic iRST;
	wordT initialPc;
	wordT memAddr;
	wordT memWriteData;
	wordT memReadData;
	logic memWriteEn;
	logic memReadEn;
	byteEnT memByteEn;

	wordT mem [memWords]; // Memory seen by the DUT
	wordT refMem [memWords]; // Model copy
	wordT refRegs [`cpuRegCount];
	wordT refPc;
	wordT emitPc; // Assembler write pointer
	int progLen;
	int cycles;
	int limit;
	integer seed;
	logic doneRun;

	// Expected bus activity from the model
	logic storePending;
	wordT expStoreAddr;
	byteEnT expLanes;
	wordT expStoreData;
	logic loadPending;
	wordT expLoadAddr;
	wordT fetchPc;
	wordT fetchInstr;
	wordT laneMask;

	multiCycleCpu dut_i (
		.iCLK(iCLK),
		.iRST(iRST),
		.initialPc(initialPc),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.memWriteEn(memWriteEn),
		.memReadEn(memReadEn),
		.memByteEn(memByteEn)
	);

	always #10 iCLK = ~iCLK;

	assign memReadData = mem[memAddr[10:2]]; // Combinational read

	// Byte-lane write at the edge
	always @(posedge iCLK)
	begin
		if (memWriteEn)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (memByteEn[b])
					mem[memAddr[10:2]][8*b +: 8] <= memWriteData[8*b +: 8];
			end
		end
	end

	// Instruction encoders
	function automatic wordT encR(input int rs, input int rt, input int rd, input functT fn);
		encR = {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic wordT encI(input opcodeT op, input int rs, input int rt, input int imm);
		encI = {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic wordT encJ(input opcodeT op, input wordT target);
		encJ = {op, target[27:2]};
	endfunction

	task automatic emit(input wordT instr);
		mem[emitPc[10:2]] = instr;
		refMem[emitPc[10:2]] = instr;
		emitPc = emitPc + `cpuPcStep;
		progLen++;
	endtask

	task automatic stopRun();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic compareVal(input string name, input wordT actual, input wordT expected);
		if (actual !== expected)
		begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	// Reference model, one instruction per call
	function automatic wordT modelStep(
		input wordT pcNow,
		input wordT instr,
		output logic isStore,
		output wordT stAddr,
		output byteEnT stLanes,
		output wordT stData,
		output logic isLoad,
		output wordT ldAddr
	);
		opcodeT op;
		functT fn;
		int rs;
		int rt;
		int rd;
		int dest;
		wordT sImm;
		wordT zImm;
		wordT a;
		wordT b;
		wordT res;
		wordT word;
		wordT nextPc;
		logic [7:0] bt;
		op = instr[31:26];
		fn = instr[5:0];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		sImm = {{16{instr[15]}}, instr[15:0]};
		zImm = {16'h0000, instr[15:0]};
		a = refRegs[rs];
		b = refRegs[rt];
		nextPc = pcNow + 4;
		isStore = 1'b0;
		isLoad = 1'b0;
		stAddr = '0;
		stLanes = '0;
		stData = '0;
		ldAddr = '0;
		dest = -1;
		res = '0;
		case (op)
			`cpuOpRType:
			begin
				dest = rd;
				case (fn)
					`cpuFnAdd: res = a + b;
					`cpuFnSub: res = a - b;
					`cpuFnAnd: res = a & b;
					`cpuFnOr: res = a | b;
					`cpuFnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					`cpuFnJr:
					begin
						dest = -1;
						nextPc = a;
					end
					default: res = a + b;
				endcase
			end
			`cpuOpAddi:
			begin
				dest = rt;
				res = a + sImm;
			end
			`cpuOpAndi:
			begin
				dest = rt;
				res = a & zImm;
			end
			`cpuOpOri:
			begin
				dest = rt;
				res = a | zImm;
			end
			`cpuOpLw, `cpuOpLb, `cpuOpLbu:
			begin
				isLoad = 1'b1;
				ldAddr = a + sImm;
				word = refMem[ldAddr[10:2]];
				bt = word >> (8 * ldAddr[1:0]); // Little-endian lane
				dest = rt;
				if (op == `cpuOpLw)
					res = word;
				else if (op == `cpuOpLb)
					res = {{24{bt[7]}}, bt};
				else
					res = {24'h000000, bt};
			end
			`cpuOpSw, `cpuOpSb:
			begin
				isStore = 1'b1;
				stAddr = a + sImm;
				if (op == `cpuOpSw)
				begin
					stLanes = 4'hf;
					stData = b;
				end
				else
				begin
					stLanes = 4'b0001 << stAddr[1:0];
					stData = {4{b[7:0]}}; // Byte copied on every lane
				end
				for (int k = 0; k < 4; k++)
				begin
					if (stLanes[k])
						refMem[stAddr[10:2]][8*k +: 8] = stData[8*k +: 8];
				end
			end
			`cpuOpBeq:
			begin
				if (a == b)
					nextPc = pcNow + 4 + (sImm << 2);
			end
			`cpuOpBne:
			begin
				if (a != b)
					nextPc = pcNow + 4 + (sImm << 2);
			end
			`cpuOpJ: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
			`cpuOpJal:
			begin
				dest = `cpuRaReg;
				res = pcNow + 4; // Link
				nextPc = {nextPc[31:28], instr[25:0], 2'b00};
			end
			default: dest = -1; // Nop
		endcase
		if (dest > 0)
			refRegs[dest] = res; // r0 stays zero
		modelStep = nextPc;
	endfunction

	// Bus checker, sampled before the DUT updates at the edge
	always @(posedge iCLK)
	begin
		if (!iRST)
		begin
			if (memWriteEn)
			begin
				if (!storePending)
				begin
					$display("Memory write seen where no store was expected");
					stopRun();
				end
				laneMask = {{8{expLanes[3]}}, {8{expLanes[2]}}, {8{expLanes[1]}}, {8{expLanes[0]}}};
				compareVal("memAddr", memAddr, expStoreAddr);
				compareVal("memByteEn", wordT'(memByteEn), wordT'(expLanes));
				compareVal("memWriteData", memWriteData & laneMask, expStoreData & laneMask);
				storePending = 1'b0;
			end
			if (memReadEn)
			begin
				if (loadPending)
				begin
					compareVal("memAddr", memAddr, expLoadAddr); // Data read of a load
					loadPending = 1'b0;
				end
				else
				begin
					if (storePending)
					begin
						$display("Next fetch started before the expected store was written");
						stopRun();
					end
					compareVal("memAddr", memAddr, refPc);
					fetchPc = refPc;
					fetchInstr = refMem[refPc[10:2]];
					refPc = modelStep(fetchPc, fetchInstr, storePending, expStoreAddr, expLanes,
						expStoreData, loadPending, expLoadAddr);
					if (fetchInstr[31:26] == `cpuOpJ && refPc == fetchPc)
						doneRun = 1'b1; // Final self-jump
				end
			end
		end
	end

	initial
	begin
		wordT addr;
		iCLK = 1'b0;
		iRST = 1'b1;
		initialPc = progBase;
		seed = 64;
		doneRun = 1'b0;
		storePending = 1'b0;
		loadPending = 1'b0;
		progLen = 0;
		cycles = 0;
		refPc = progBase;
		for (int i = 0; i < `cpuRegCount; i++)
			refRegs[i] = '0;

		// Random data region, address pattern elsewhere
		for (int i = 0; i < memWords; i++)
		begin
			addr = i * 4;
			if (addr >= dataBase && addr < resBase)
				mem[i] = $random(seed);
			else
				mem[i] = (addr * 32'h0001_0003) ^ 32'h5a5a_0000;
			refMem[i] = mem[i];
		end
		mem[(dataBase + 8) >> 2] = 32'h7f80_01fe; // Both signs in the byte tests
		refMem[(dataBase + 8) >> 2] = 32'h7f80_01fe;

		emitPc = progBase;
		emit(encI(`cpuOpAddi, 0, 20, dataBase)); // r20 data pointer
		emit(encI(`cpuOpAddi, 0, 21, resBase)); // r21 result pointer
		emit(encI(`cpuOpLw, 20, 1, 0));
		emit(encI(`cpuOpLw, 20, 2, 4));
		// ALU ops, each result stored
		emit(encR(1, 2, 3, `cpuFnAdd));
		emit(encI(`cpuOpSw, 21, 3, 0));
		emit(encR(1, 2, 4, `cpuFnSub));
		emit(encI(`cpuOpSw, 21, 4, 4));
		emit(encR(1, 2, 5, `cpuFnAnd));
		emit(encI(`cpuOpSw, 21, 5, 8));
		emit(encR(1, 2, 6, `cpuFnOr));
		emit(encI(`cpuOpSw, 21, 6, 12));
		emit(encR(1, 2, 7, `cpuFnSlt));
		emit(encI(`cpuOpSw, 21, 7, 16));
		emit(encR(2, 1, 8, `cpuFnSlt));
		emit(encI(`cpuOpSw, 21, 8, 20));
		emit(encI(`cpuOpAddi, 1, 9, -5));
		emit(encI(`cpuOpSw, 21, 9, 24));
		emit(encI(`cpuOpAndi, 1, 10, 16'hf0f0));
		emit(encI(`cpuOpSw, 21, 10, 28));
		emit(encI(`cpuOpOri, 2, 11, 16'h8001));
		emit(encI(`cpuOpSw, 21, 11, 32));
		// sb on every lane
		for (int k = 0; k < 4; k++)
			emit(encI(`cpuOpSb, 21, 1, 40 + k));
		// lb and lbu from every offset
		for (int k = 0; k < 4; k++)
		begin
			emit(encI(`cpuOpLb, 20, 12, 8 + k));
			emit(encI(`cpuOpSw, 21, 12, 48 + 8 * k));
			emit(encI(`cpuOpLbu, 20, 13, 8 + k));
			emit(encI(`cpuOpSw, 21, 13, 52 + 8 * k));
		end
		// Branches taken and not taken
		emit(encI(`cpuOpAddi, 0, 14, 1));
		emit(encI(`cpuOpBeq, 14, 0, 1)); // Not taken
		emit(encI(`cpuOpAddi, 0, 15, 16'h11));
		emit(encI(`cpuOpBeq, 14, 14, 1)); // Taken
		emit(encI(`cpuOpAddi, 0, 15, 16'h22));
		emit(encI(`cpuOpBne, 14, 14, 1)); // Not taken
		emit(encI(`cpuOpAddi, 15, 15, 16'h100));
		emit(encI(`cpuOpBne, 14, 0, 1)); // Taken
		emit(encI(`cpuOpAddi, 0, 15, 16'h44));
		emit(encJ(`cpuOpJ, emitPc + 8)); // Skip one
		emit(encI(`cpuOpAddi, 0, 15, 16'h99));
		emit(encI(`cpuOpSw, 21, 15, 88));
		// Call and return
		emit(encJ(`cpuOpJal, subBase));
		emit(encI(`cpuOpSw, 21, `cpuRaReg, 92));
		// r0 write ignored
		emit(encI(`cpuOpAddi, 0, 0, 16'h55));
		emit(encI(`cpuOpSw, 21, 0, 96));
		emit(encJ(`cpuOpJ, emitPc)); // Self-jump ends the program

		emitPc = subBase;
		emit(encI(`cpuOpAddi, 0, 16, 16'h33));
		emit(encI(`cpuOpSw, 21, 16, 100));
		emit(encR(`cpuRaReg, 0, 0, `cpuFnJr));

		limit = 5 * progLen + 10 + 50; // No loops, so bounded by program length

		repeat (10) @(negedge iCLK);
		iRST = 1'b0;

		while (!doneRun && cycles < limit)
		begin
			@(posedge iCLK);
			cycles++;
		end
		if (doneRun)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			$display("Core stalled, final self-jump not reached after %0d cycles", cycles);
			stopRun();
		end
	end

endmodule
